/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [63:0] word_t;    // register, pc and memory word
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF,     // value read in decode
        FWD_MEM,    // EX/MEM result
        FWD_WB      // MEM/WB result
    } fwd_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;
    localparam logic [2:0] F3_ADD    = 3'b000;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_DOUBLE = 3'b011;    // ld / sd width

    localparam logic [6:0] F7_SUB    = 7'b0100000;

    localparam word_t RESET_PC = 64'h0;
    localparam inst_t NOP_INST = 32'h00000013;   // addi x0, x0, 0

endpackage

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  inst_t    id_inst,
    input  word_t    id_pc,
    input  logic     id_valid,
    input  logic     stall,
    input  logic     redirect,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output word_t    ex_pc,
    output word_t    ex_imm,
    output word_t    ex_rs1_data,
    output word_t    ex_rs2_data,
    output reg_idx_t ex_rs1_idx,
    output reg_idx_t ex_rs2_idx,
    output reg_idx_t ex_rd,
    output alu_op_e  ex_alu_op,
    output wb_sel_e  ex_wb_sel,
    output logic     ex_alu_src_imm,
    output logic     ex_reg_write,
    output logic     ex_mem_read,
    output logic     ex_mem_write,
    output logic     ex_branch,
    output logic     ex_branch_ne,
    output logic     ex_jal,
    output logic     ex_valid
);

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    word_t      imm_i, imm_s, imm_b, imm_j, dec_imm;
    alu_op_e    dec_alu_op;
    wb_sel_e    dec_wb_sel;
    logic       use_rs1, use_rs2, dec_alu_src_imm, dec_reg_write;
    logic       dec_mem_read, dec_mem_write, dec_branch, dec_branch_ne, dec_jal;
    logic       bubble;

    assign opcode = id_inst[6:0];
    assign funct3 = id_inst[14:12];
    assign funct7 = id_inst[31:25];

    assign imm_i = {{52{id_inst[31]}}, id_inst[31:20]};
    assign imm_s = {{52{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
    assign imm_b = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_j = {{43{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    always_comb begin
        use_rs1         = 1'b0;
        use_rs2         = 1'b0;
        dec_imm         = imm_i;
        dec_alu_op      = ALU_ADD;
        dec_wb_sel      = WB_ALU;
        dec_alu_src_imm = 1'b0;
        dec_reg_write   = 1'b0;
        dec_mem_read    = 1'b0;
        dec_mem_write   = 1'b0;
        dec_branch      = 1'b0;
        dec_branch_ne   = 1'b0;
        dec_jal         = 1'b0;
        case (opcode)
            OP_REG: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec_reg_write = 1'b1;
                if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    dec_alu_op = ALU_SUB;
                end else if (funct7 != 7'b0) begin
                    dec_reg_write = 1'b0;    // unsupported, retire as nop
                end else begin
                    case (funct3)
                        F3_ADD:  dec_alu_op = ALU_ADD;
                        F3_SLT:  dec_alu_op = ALU_SLT;
                        F3_OR:   dec_alu_op = ALU_OR;
                        F3_AND:  dec_alu_op = ALU_AND;
                        default: dec_reg_write = 1'b0;
                    endcase
                end
            end
            OP_IMM: begin
                use_rs1         = (funct3 == F3_ADD);
                dec_alu_src_imm = 1'b1;
                dec_reg_write   = (funct3 == F3_ADD);    // addi only
            end
            OP_LOAD: begin
                use_rs1         = (funct3 == F3_DOUBLE);
                dec_alu_src_imm = 1'b1;
                dec_reg_write   = (funct3 == F3_DOUBLE);
                dec_mem_read    = (funct3 == F3_DOUBLE);
                dec_wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                use_rs1         = (funct3 == F3_DOUBLE);
                use_rs2         = (funct3 == F3_DOUBLE);
                dec_imm         = imm_s;
                dec_alu_src_imm = 1'b1;
                dec_mem_write   = (funct3 == F3_DOUBLE);
            end
            OP_BRANCH: begin
                use_rs1       = (funct3 == F3_BEQ || funct3 == F3_BNE);
                use_rs2       = use_rs1;
                dec_imm       = imm_b;
                dec_alu_op    = ALU_SUB;
                dec_branch    = use_rs1;
                dec_branch_ne = (funct3 == F3_BNE);
            end
            OP_JAL: begin
                dec_imm       = imm_j;
                dec_reg_write = 1'b1;
                dec_jal       = 1'b1;
                dec_wb_sel    = WB_PC4;    // link value
            end
            default: ;
        endcase
    end

    // unused source fields read as x0 so they never stall or forward
    assign rs1_idx = use_rs1 ? id_inst[19:15] : '0;
    assign rs2_idx = use_rs2 ? id_inst[24:20] : '0;

    assign bubble = stall || redirect || !id_valid;

    always_ff @(posedge clk) begin
        if (!rst_n || bubble) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_branch_ne <= 1'b0;
            ex_jal       <= 1'b0;
            ex_rd        <= '0;
            ex_rs1_idx   <= '0;
            ex_rs2_idx   <= '0;
        end else begin
            ex_valid     <= 1'b1;
            ex_reg_write <= dec_reg_write;
            ex_mem_read  <= dec_mem_read;
            ex_mem_write <= dec_mem_write;
            ex_branch    <= dec_branch;
            ex_branch_ne <= dec_branch_ne;
            ex_jal       <= dec_jal;
            ex_rd        <= id_inst[11:7];
            ex_rs1_idx   <= rs1_idx;
            ex_rs2_idx   <= rs2_idx;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc          <= id_pc;
        ex_imm         <= dec_imm;
        ex_rs1_data    <= rs1_data;
        ex_rs2_data    <= rs2_data;
        ex_alu_op      <= dec_alu_op;
        ex_wb_sel      <= dec_wb_sel;
        ex_alu_src_imm <= dec_alu_src_imm;
    end

    a_no_load_store : assert property (@(posedge clk) disable iff (!rst_n)
        !(ex_mem_read && ex_mem_write));

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t debug_reg_addr,
    input  reg_idx_t wb_rd,
    input  logic     wb_en,
    input  word_t    wb_data,
    output word_t    rs1_data,
    output word_t    rs2_data,
    output word_t    debug_reg_data
);

    word_t regs [32];
    logic  wr_ok;

    assign wr_ok = wb_en && wb_rd != '0;    // x0 is never written

    function automatic word_t read_port(reg_idx_t idx, logic wr, reg_idx_t wr_idx,
                                        word_t wr_val, word_t stored);
        return (wr && wr_idx == idx) ? wr_val : stored;    // write-through
    endfunction

    assign rs1_data       = read_port(rs1_idx, wr_ok, wb_rd, wb_data, regs[rs1_idx]);
    assign rs2_data       = read_port(rs2_idx, wr_ok, wb_rd, wb_data, regs[rs2_idx]);
    assign debug_reg_data = read_port(debug_reg_addr, wr_ok, wb_rd, wb_data,
                                      regs[debug_reg_addr]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_ok) begin
            regs[wb_rd] <= wb_data;
        end
    end

    a_x0_zero : assert property (@(posedge clk) disable iff (!rst_n)
        (rs1_idx == '0 -> rs1_data == '0) && (rs2_idx == '0 -> rs2_data == '0));

endmodule

`default_nettype wire

/* files.f */
+incdir+verification
common/rv_pkg.sv
src/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
src/execute_stage.sv
src/hazard_unit.sv
src/mem_wb_stage.sv
src/rv_core.sv
verification/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# compile and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f files.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

/* src/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    ex_pc,
    input  word_t    ex_imm,
    input  word_t    ex_rs1_data,
    input  word_t    ex_rs2_data,
    input  reg_idx_t ex_rd,
    input  alu_op_e  ex_alu_op,
    input  wb_sel_e  ex_wb_sel,
    input  logic     ex_alu_src_imm,
    input  logic     ex_reg_write,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  logic     ex_branch,
    input  logic     ex_branch_ne,
    input  logic     ex_jal,
    input  logic     ex_valid,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    input  word_t    wb_data,
    output logic     redirect,
    output word_t    redirect_pc,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output word_t    mem_result,
    output reg_idx_t mem_rd,
    output logic     mem_reg_write,
    output logic     mem_mem_read,
    output logic     mem_mem_write,
    output wb_sel_e  mem_wb_sel
);

    word_t op_a, rs2_val, op_b, alu_res, ex_result;
    logic  equal;
    logic  mem_valid, reg_write_q, mem_read_q, mem_write_q;

    function automatic word_t pick_operand(fwd_sel_e sel, word_t rf_val, word_t mem_val,
                                           word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign op_a    = pick_operand(fwd_a, ex_rs1_data, mem_result, wb_data);
    assign rs2_val = pick_operand(fwd_b, ex_rs2_data, mem_result, wb_data);
    assign op_b    = ex_alu_src_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_SLT: alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    // predict not taken, so only a taken transfer redirects
    assign equal       = (op_a == rs2_val);
    assign redirect    = ex_valid && (ex_jal || (ex_branch && (equal != ex_branch_ne)));
    assign redirect_pc = ex_pc + ex_imm;

    assign ex_result = (ex_wb_sel == WB_PC4) ? ex_pc + 64'd4 : alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid   <= 1'b0;
            reg_write_q <= 1'b0;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
            mem_rd      <= '0;
        end else begin
            mem_valid   <= ex_valid;
            reg_write_q <= ex_reg_write;
            mem_read_q  <= ex_mem_read;
            mem_write_q <= ex_mem_write;
            mem_rd      <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr   <= alu_res;
        mem_wdata  <= rs2_val;    // store data after forwarding
        mem_result <= ex_result;
        mem_wb_sel <= ex_wb_sel;
    end

    assign mem_reg_write = reg_write_q && mem_valid;
    assign mem_mem_read  = mem_read_q && mem_valid;
    assign mem_mem_write = mem_write_q && mem_valid;

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    input  inst_t inst,
    output word_t pc_out,
    output inst_t id_inst,
    output word_t id_pc,
    output logic  id_valid
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_out   <= RESET_PC;
            id_inst  <= NOP_INST;
            id_valid <= 1'b0;
        end else if (redirect) begin     // taken branch or jal in EX
            pc_out   <= redirect_pc;
            id_inst  <= NOP_INST;
            id_valid <= 1'b0;
        end else if (!stall) begin
            pc_out   <= pc_out + 64'd4;
            id_inst  <= inst;
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc <= pc_out;
        end
    end

    a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
        pc_out[1:0] == 2'b00);

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import rv_pkg::*; (
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t ex_rs1_idx,
    input  reg_idx_t ex_rs2_idx,
    input  reg_idx_t ex_rd,
    input  reg_idx_t mem_rd,
    input  reg_idx_t wb_rd,
    input  logic     ex_mem_read,
    input  logic     mem_reg_write,
    input  logic     wb_reg_write,
    output logic     stall,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    logic load_dest;

    function automatic fwd_sel_e pick_source(reg_idx_t src, reg_idx_t m_rd, logic m_we,
                                             reg_idx_t w_rd, logic w_we);
        if (src == '0) return FWD_RF;
        if (m_we && m_rd == src) return FWD_MEM;    // youngest result wins
        if (w_we && w_rd == src) return FWD_WB;
        return FWD_RF;
    endfunction

    assign load_dest = ex_mem_read && ex_rd != '0;
    assign stall     = load_dest && (ex_rd == rs1_idx || ex_rd == rs2_idx);

    assign fwd_a = pick_source(ex_rs1_idx, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
    assign fwd_b = pick_source(ex_rs2_idx, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

endmodule

`default_nettype wire

/* src/mem_wb_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_wb_stage import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    mem_addr,
    input  word_t    mem_wdata,
    input  word_t    mem_result,
    input  reg_idx_t mem_rd,
    input  logic     mem_reg_write,
    input  logic     mem_mem_read,
    input  logic     mem_mem_write,
    input  wb_sel_e  mem_wb_sel,
    input  word_t    data_in,
    output word_t    addr_out,
    output word_t    data_out,
    output logic     mem_write,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    word_t   load_q, result_q;
    wb_sel_e wb_sel_q;

    assign addr_out  = mem_addr;
    assign data_out  = mem_wdata;
    assign mem_write = mem_mem_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
            wb_rd <= '0;
        end else begin
            wb_en <= mem_reg_write;
            wb_rd <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        result_q <= mem_result;
        wb_sel_q <= mem_wb_sel;
        if (mem_mem_read) begin
            load_q <= data_in;    // combinational memory read
        end
    end

    always_comb begin
        case (wb_sel_q)
            WB_MEM:  wb_data = load_q;
            default: wb_data = result_q;    // alu or link, picked in EX
        endcase
    end

    a_store_aligned : assert property (@(posedge clk) disable iff (!rst_n)
        mem_write |-> addr_out[2:0] == 3'b000);

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  inst_t    inst,
    output word_t    pc_out,
    output word_t    addr_out,
    output word_t    data_out,
    output logic     mem_write,
    input  word_t    data_in,
    input  reg_idx_t debug_reg_addr,
    output word_t    debug_reg_data
);

    logic     stall, redirect;
    word_t    redirect_pc;
    inst_t    id_inst;
    word_t    id_pc;
    logic     id_valid;

    reg_idx_t rs1_idx, rs2_idx;
    word_t    rs1_data, rs2_data;

    word_t    ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
    reg_idx_t ex_rs1_idx, ex_rs2_idx, ex_rd;
    alu_op_e  ex_alu_op;
    wb_sel_e  ex_wb_sel;
    logic     ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic     ex_branch, ex_branch_ne, ex_jal, ex_valid;
    fwd_sel_e fwd_a, fwd_b;

    word_t    mem_addr, mem_wdata, mem_result;
    reg_idx_t mem_rd;
    logic     mem_reg_write, mem_mem_read, mem_mem_write;
    wb_sel_e  mem_wb_sel;

    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    fetch_stage i_fetch_stage (.*);

    decode_stage i_decode_stage (.*);

    reg_file i_reg_file (.*);

    hazard_unit i_hazard_unit (
        .*,
        .wb_reg_write(wb_en)
    );

    execute_stage i_execute_stage (.*);

    mem_wb_stage i_mem_wb_stage (.*);

endmodule

`default_nettype wire

/* verification/rv_ref_model.svh */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// ISA-level interpreter of the kept subset, fills ref_regs and the store list
function automatic int run_reference();
    word_t    mem [DMEM_WORDS];
    word_t    pc, next_pc, a, b, res;
    word_t    imm_i, imm_s, imm_b, imm_j;
    inst_t    ins;
    reg_idx_t rd;
    logic     wr, halted;
    int       count;
    mem    = dmem_init;
    pc     = RESET_PC;
    count  = 0;
    halted = 1'b0;
    foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
    end
    while (!halted && count < 10 * IMEM_WORDS) begin
        ins     = imem[pc[7:2]];
        a       = ref_regs[ins[19:15]];
        b       = ref_regs[ins[24:20]];
        rd      = ins[11:7];
        imm_i   = {{52{ins[31]}}, ins[31:20]};
        imm_s   = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j   = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        next_pc = pc + 64'd4;
        wr      = 1'b0;
        res     = '0;
        case (ins[6:0])
            OP_REG: begin
                wr = 1'b1;
                case ({ins[31:25], ins[14:12]})
                    {7'b0, F3_ADD}:   res = a + b;
                    {F7_SUB, F3_ADD}: res = a - b;
                    {7'b0, F3_SLT}:   res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    {7'b0, F3_OR}:    res = a | b;
                    {7'b0, F3_AND}:   res = a & b;
                    default:          wr = 1'b0;    // not kept, acts as nop
                endcase
            end
            OP_IMM: begin
                wr  = (ins[14:12] == F3_ADD);
                res = a + imm_i;
            end
            OP_LOAD: begin
                wr  = (ins[14:12] == F3_DOUBLE);
                res = a + imm_i;
                res = mem[res[7:3]];
            end
            OP_STORE: begin
                if (ins[14:12] == F3_DOUBLE) begin
                    res = a + imm_s;
                    mem[res[7:3]] = b;
                    exp_addr.push_back(res);
                    exp_data.push_back(b);
                end
            end
            OP_BRANCH: begin
                if ((ins[14:12] == F3_BEQ && a == b) || (ins[14:12] == F3_BNE && a != b)) begin
                    next_pc = pc + imm_b;
                end
            end
            OP_JAL: begin
                wr      = 1'b1;
                res     = pc + 64'd4;    // link
                next_pc = pc + imm_j;
            end
            default: ;
        endcase
        if (wr && rd != 5'd0) begin
            ref_regs[rd] = res;
        end
        halted = (ins == HALT_INST);
        pc     = next_pc;
        count++;
    end
    return count;
endfunction

`endif

/* verification/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    localparam int    IMEM_WORDS     = 64;
    localparam int    DMEM_WORDS     = 32;
    localparam inst_t HALT_INST      = 32'h0000006f;    // jal x0, 0
    localparam int    SEED_INIT      = 27;
    localparam int    TIMEOUT_MARGIN = 60;
    localparam int    HALT_VISITS    = 8;

    logic     clk;
    logic     rst_n;
    inst_t    inst;
    word_t    pc_out, addr_out, data_out, data_in, debug_reg_data;
    logic     mem_write;
    reg_idx_t debug_reg_addr;

    inst_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t dmem_init [DMEM_WORDS];
    word_t ref_regs [32];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t halt_pc;
    int    seed, n_inst, steps, timeout_limit;
    int    store_idx   = 0;
    int    cycle_count = 0;
    int    halt_visits = 0;
    logic  dumping;

    `include "rv_ref_model.svh"

    rv_core i_rv_core (.*);

    always #10 clk = ~clk;

    assign inst    = (pc_out < 64'(IMEM_WORDS * 4)) ? imem[pc_out[7:2]] : NOP_INST;
    assign data_in = dmem[addr_out[7:3]];

    always @(posedge clk) begin
        if (!rst_n) begin
            dmem <= dmem_init;    // reload initial image
        end else if (mem_write) begin
            dmem[addr_out[7:3]] <= data_out;
        end
    end

    function automatic inst_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic inst_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, F3_DOUBLE, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic inst_t j_type(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic put_inst(inst_t word);
        imem[n_inst] = word;
        n_inst++;
    endtask

    // forward branches only, so the halt loop is entered exactly once
    task automatic build_program();
        logic [11:0] r1, r2, r3, r4;
        r1 = 12'($random(seed));
        r2 = 12'($random(seed));
        r3 = 12'($random(seed));
        r4 = 12'($random(seed));
        put_inst(i_type(r1, 0, F3_ADD, 1, OP_IMM));
        put_inst(i_type(r2, 0, F3_ADD, 2, OP_IMM));
        put_inst(i_type(r3, 1, F3_ADD, 3, OP_IMM));       // dependent chain
        put_inst(r_type(7'b0, 2, 3, F3_ADD, 4));
        put_inst(r_type(F7_SUB, 1, 4, F3_ADD, 5));
        put_inst(r_type(7'b0, 3, 5, F3_AND, 6));
        put_inst(r_type(7'b0, 2, 6, F3_OR, 7));
        put_inst(r_type(7'b0, 2, 1, F3_SLT, 8));
        put_inst(r_type(7'b0, 1, 2, F3_SLT, 9));
        put_inst(i_type(12'hffb, 0, F3_ADD, 24, OP_IMM));  // -5
        put_inst(r_type(7'b0, 24, 0, F3_SLT, 25));
        put_inst(r_type(7'b0, 0, 24, F3_SLT, 26));
        put_inst(r_type(7'b0, 2, 1, 3'b100, 27));           // xor is not kept
        put_inst(i_type(12'd64, 0, F3_ADD, 10, OP_IMM));    // data base
        put_inst(i_type(12'd0, 10, F3_DOUBLE, 11, OP_LOAD));
        put_inst(r_type(7'b0, 1, 11, F3_ADD, 12));          // load-use
        put_inst(i_type(12'd8, 10, F3_DOUBLE, 13, OP_LOAD));
        put_inst(s_type(12'd16, 13, 10));
        put_inst(s_type(12'd24, 12, 10));
        put_inst(i_type(12'd5, 0, F3_ADD, 0, OP_IMM));
        put_inst(r_type(7'b0, 2, 1, F3_ADD, 0));
        put_inst(b_type(13'd12, 1, 1, F3_BEQ));             // taken
        put_inst(i_type(12'd1, 0, F3_ADD, 14, OP_IMM));
        put_inst(s_type(12'd32, 1, 10));
        put_inst(b_type(13'd8, 1, 1, F3_BNE));              // not taken
        put_inst(i_type(12'd7, 0, F3_ADD, 15, OP_IMM));
        put_inst(b_type(13'd12, 0, 10, F3_BNE));            // taken
        put_inst(i_type(12'd2, 0, F3_ADD, 16, OP_IMM));
        put_inst(s_type(12'd48, 2, 10));
        put_inst(b_type(13'd8, 10, 1, F3_BEQ));             // data dependent
        put_inst(i_type(12'd3, 0, F3_ADD, 28, OP_IMM));
        put_inst(j_type(21'd12, 17));
        put_inst(i_type(12'd4, 0, F3_ADD, 18, OP_IMM));
        put_inst(s_type(12'd56, 1, 10));
        put_inst(r_type(7'b0, 12, 17, F3_ADD, 19));
        put_inst(s_type(12'd40, 19, 10));
        put_inst(i_type(12'd40, 10, F3_DOUBLE, 20, OP_LOAD));
        put_inst(r_type(F7_SUB, 5, 20, F3_ADD, 21));
        put_inst(i_type(r4, 21, F3_ADD, 23, OP_IMM));
        halt_pc = word_t'(n_inst) * 64'd4;
        put_inst(HALT_INST);
    endtask

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_pc(word_t got, word_t exp);
        if (got !== exp) begin
            $display("error at %0t: pc_out = %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_store(word_t addr, word_t data, word_t exp_a, word_t exp_d);
        if (addr !== exp_a) begin
            $display("error at %0t: addr_out = %h, expected %h", $time, addr, exp_a);
            abort_run();
        end else if (data !== exp_d) begin
            $display("error at %0t: data_out = %h, expected %h", $time, data, exp_d);
            abort_run();
        end
    endtask

    task automatic check_reg(reg_idx_t idx, word_t got, word_t exp);
        if (got !== exp) begin
            $display("error at %0t: debug_reg_data (x%0d) = %h, expected %h",
                     $time, idx, got, exp);
            abort_run();
        end
    endtask

    // stores are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && mem_write) begin
            if (store_idx >= exp_addr.size()) begin
                $display("unexpected store to address %h at %0t after the last program store",
                         addr_out, $time);
                abort_run();
            end else begin
                store_idx++;
                check_store(addr_out, data_out, exp_addr[store_idx - 1],
                            exp_data[store_idx - 1]);
            end
        end
    end

    // halt loop passes halt_pc every third cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (pc_out == halt_pc) begin
                halt_visits++;
            end
            if (!dumping) begin
                cycle_count++;
                if (cycle_count > timeout_limit) begin
                    $display("timeout after %0d cycles without reaching the halt loop",
                             cycle_count);
                    abort_run();
                end
            end
        end
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        debug_reg_addr = '0;
        dumping        = 1'b0;
        seed           = SEED_INIT;
        n_inst         = 0;
        foreach (imem[i]) begin
            imem[i] = NOP_INST;
        end
        foreach (dmem_init[i]) begin
            dmem_init[i] = {$random(seed), $random(seed)};
        end
        build_program();
        steps         = run_reference();
        timeout_limit = 3 * steps + TIMEOUT_MARGIN;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_pc(pc_out, 64'h0);    // first fetch comes from address zero
        wait (halt_visits >= HALT_VISITS);
        dumping = 1'b1;
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #2;
            debug_reg_addr = reg_idx_t'(r);
            @(negedge clk);
            check_reg(debug_reg_addr, debug_reg_data, ref_regs[r]);
        end
        if (store_idx != exp_addr.size()) begin
            $display("%0d of %0d expected stores never appeared on the data port",
                     exp_addr.size() - store_idx, exp_addr.size());
            abort_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
